//--- filelist.f
hw/mem_subsys_pkg.sv
hw/bram_bus_if.sv
hw/line_bus_master.sv
hw/bram_bank.sv
hw/line_assembler.sv
hw/mem_subsys.sv
verif/mem_subsys_chk.sv
verif/mem_subsys_tb.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  # package and interface first, then the design from the leaves up
  - hw/mem_subsys_pkg.sv
  - hw/bram_bus_if.sv
  - hw/line_bus_master.sv
  - hw/bram_bank.sv
  - hw/line_assembler.sv
  - hw/mem_subsys.sv

  # bound checker and testbench, top module mem_subsys_tb
  - target: test
    files:
      - verif/mem_subsys_chk.sv
      - verif/mem_subsys_tb.sv

//--- verif/mem_subsys_tb.sv
// Directed testbench for the banked line memory, run as the simulation top
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_tb;

    localparam int ACK_TIMEOUT = 40;

    logic                  itf;
    logic                  rst;
    logic                  req;
    logic                  we;
    mem_subsys_pkg::addr_t addr;
    mem_subsys_pkg::line_t wdata;
    logic                  ack;
    mem_subsys_pkg::line_t rdata;

    int          errors;
    int          tests;
    logic [31:0] rng_state;

    // expected contents, keyed by {bank, line index}
    mem_subsys_pkg::line_t ref_mem [logic [5:0]];

    mem_subsys UUT (
        .itf   (itf),
        .rst   (rst),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata)
    );

    always #4 itf = ~itf;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic mem_subsys_pkg::line_t random_line();
        mem_subsys_pkg::line_t l;
        for (int k = 0; k < mem_subsys_pkg::BEATS; k++) begin
            rng_state = xorshift32(rng_state);
            l[k*32 +: 32] = rng_state;
        end
        return l;
    endfunction

    // bits 10..7 line, 6..5 bank, offset left at zero
    function automatic mem_subsys_pkg::addr_t line_addr(input mem_subsys_pkg::bank_idx_t b,
                                                        input mem_subsys_pkg::line_idx_t l);
        return mem_subsys_pkg::addr_t'({l, b, 5'b0});
    endfunction

    function automatic logic [5:0] ref_key(input mem_subsys_pkg::addr_t a);
        return {a[6:5], a[10:7]};
    endfunction

    task automatic compare_line(input string name, input mem_subsys_pkg::line_t got,
                                input mem_subsys_pkg::line_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // polls ack on falling edges, returns how many edges it took
    task automatic wait_for_ack(input logic level, output int cycles);
        cycles = 0;
        while (ack !== level && cycles < ACK_TIMEOUT) begin
            @(negedge itf);
            cycles++;
        end
        if (ack !== level) begin
            $display("ERROR at %0t: ack did not go to %b within %0d cycles",
                     $time, level, ACK_TIMEOUT);
            errors++;
        end
    endtask

    task automatic line_write(input mem_subsys_pkg::addr_t a, input mem_subsys_pkg::line_t d);
        int n;
        @(negedge itf);
        addr  = a;
        we    = 1'b1;
        wdata = d;
        req   = 1'b1;
        wait_for_ack(1'b1, n);
        req = 1'b0;
        wait_for_ack(1'b0, n);
        ref_mem[ref_key(a)] = d;
    endtask

    // hold keeps req high for that many extra cycles after ack
    task automatic line_read(input mem_subsys_pkg::addr_t a, input int hold,
                             output mem_subsys_pkg::line_t d, output int latency);
        int n;
        @(negedge itf);
        addr = a;
        we   = 1'b0;
        req  = 1'b1;
        wait_for_ack(1'b1, n);
        // first edge after req goes high is the sampling edge
        latency = n - 1;
        d = rdata;
        repeat (hold) begin
            @(negedge itf);
            compare_bit("ack", ack, 1'b1);
            compare_line("rdata", rdata, d);
        end
        req = 1'b0;
        wait_for_ack(1'b0, n);
        compare_count("ack fall cycles", n, 1);
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        if (errors == start) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - start);
        end
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        rst = 1'b1;
        repeat (5) begin
            @(negedge itf);
            compare_bit("ack", ack, 1'b0);
        end
        rst = 1'b0;
        repeat (10) begin
            @(negedge itf);
            compare_bit("ack", ack, 1'b0);
        end
        report_test("reset", start);
    endtask

    task automatic test_write_read();
        int                    start;
        int                    lat;
        mem_subsys_pkg::addr_t a;
        mem_subsys_pkg::line_t got;
        start = errors;
        a = line_addr(2'd1, 4'd3);
        line_write(a, random_line());
        line_read(a, 0, got, lat);
        compare_line("rdata", got, ref_mem[ref_key(a)]);
        compare_count("read latency", lat, 12);
        report_test("write_read", start);
    endtask

    task automatic test_all_banks();
        int                    start;
        int                    lat;
        mem_subsys_pkg::addr_t a;
        mem_subsys_pkg::line_t got;
        start = errors;
        for (int b = 0; b < mem_subsys_pkg::NUM_BANKS; b++) begin
            a = line_addr(mem_subsys_pkg::bank_idx_t'(b), 4'd5);
            line_write(a, random_line());
        end
        // reverse order so each bank is read after the others were written
        for (int b = mem_subsys_pkg::NUM_BANKS - 1; b >= 0; b--) begin
            a = line_addr(mem_subsys_pkg::bank_idx_t'(b), 4'd5);
            line_read(a, 0, got, lat);
            compare_line("rdata", got, ref_mem[ref_key(a)]);
        end
        report_test("all_banks", start);
    endtask

    task automatic test_overwrite();
        int                    start;
        int                    lat;
        mem_subsys_pkg::addr_t a_old;
        mem_subsys_pkg::addr_t a_nb;
        mem_subsys_pkg::line_t got;
        start = errors;
        a_old = line_addr(2'd2, 4'd7);
        a_nb  = line_addr(2'd2, 4'd8);
        line_write(a_old, random_line());
        line_write(a_nb, random_line());
        line_write(a_old, random_line());
        line_read(a_old, 0, got, lat);
        compare_line("rdata", got, ref_mem[ref_key(a_old)]);
        line_read(a_nb, 0, got, lat);
        compare_line("rdata", got, ref_mem[ref_key(a_nb)]);
        report_test("overwrite", start);
    endtask

    task automatic test_address();
        int                    start;
        int                    lat;
        mem_subsys_pkg::addr_t a;
        mem_subsys_pkg::line_t got;
        start = errors;
        a = line_addr(2'd3, 4'd9);
        line_write(a, random_line());
        // offset bits set
        line_read(a | 32'h0000_001d, 0, got, lat);
        compare_line("rdata", got, ref_mem[ref_key(a)]);
        // alias through bits 31..11
        line_read(a | 32'habcd_f800, 0, got, lat);
        compare_line("rdata", got, ref_mem[ref_key(a)]);
        report_test("address", start);
    endtask

    task automatic test_hold();
        int                    start;
        int                    lat;
        mem_subsys_pkg::addr_t a;
        mem_subsys_pkg::line_t got;
        start = errors;
        a = line_addr(2'd0, 4'd12);
        line_write(a, random_line());
        line_read(a, 6, got, lat);
        compare_line("rdata", got, ref_mem[ref_key(a)]);
        report_test("hold", start);
    endtask

    initial begin
        int total;
        itf       = 1'b0;
        rst       = 1'b1;
        req       = 1'b0;
        we        = 1'b0;
        addr      = '0;
        wdata     = '0;
        errors    = 0;
        tests     = 0;
        rng_state = 32'h28af4057;

        test_reset();
        test_write_read();
        test_all_banks();
        test_overwrite();
        test_address();
        test_hold();

        total = errors + UUT.u_chk.fails;
        $display("%0d tests run, %0d errors, %0d assertion failures",
                 tests, errors, UUT.u_chk.fails);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/mem_subsys_chk.sv
// Bound checker on the host req/ack handshake and on every bank bus, attach with bind
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_chk (
    input wire logic itf,
    input wire logic rst,
    input wire logic req,
    input wire logic ack,
    bram_bus_if      banks [mem_subsys_pkg::NUM_BANKS]
);

    // read by the testbench at the end of the run
    int fails = 0;

    // ack rises only for a request sampled on the edge before
    a_ack_rise: assert property (@(posedge itf) disable iff (rst) $rose(ack) |-> $past(req))
        else begin
            $error("ack rose without a pending request");
            fails++;
        end

    a_ack_idle: assert property (@(posedge itf) disable iff (rst) !req && !ack |=> !ack)
        else begin
            $error("ack went high while req stayed low");
            fails++;
        end

    a_ack_hold: assert property (@(posedge itf) disable iff (rst) req && ack |=> ack)
        else begin
            $error("ack dropped while req was still high");
            fails++;
        end

    a_ack_release: assert property (@(posedge itf) disable iff (rst) !req && ack |=> !ack)
        else begin
            $error("ack did not fall the cycle after req went low");
            fails++;
        end

    // host side of the four-phase order
    a_req_wait: assert property (@(posedge itf) disable iff (rst) !req && ack |=> !req)
        else begin
            $error("req raised again before ack was low");
            fails++;
        end

    for (genvar g = 0; g < mem_subsys_pkg::NUM_BANKS; g++) begin : g_bus
        a_en_excl: assert property (@(posedge itf) disable iff (rst)
                                    !(banks[g].read_en && banks[g].write_en))
            else begin
                $error("bank %0d has read_en and write_en high together", g);
                fails++;
            end

        a_resp_en: assert property (@(posedge itf) disable iff (rst)
                                    banks[g].resp |-> (banks[g].read_en || banks[g].write_en))
            else begin
                $error("bank %0d raised resp with both enables low", g);
                fails++;
            end
    end

endmodule

bind mem_subsys mem_subsys_chk u_chk (
    .itf   (itf),
    .rst   (rst),
    .req   (req),
    .ack   (ack),
    .banks (bus_if)
);

`default_nettype wire

//--- hw/mem_subsys.sv
// Top level of the banked line memory: host handshake ports, master, four banks, assembler
`timescale 1ns/10ps
`default_nettype none

module mem_subsys (
    input  wire logic                   itf,
    input  wire logic                   rst,
    input  wire logic                   req,
    input  wire logic                   we,
    input  wire mem_subsys_pkg::addr_t  addr,
    input  wire mem_subsys_pkg::line_t  wdata,
    output logic                        ack,
    output mem_subsys_pkg::line_t       rdata
);

    // one narrow bus per bank
    bram_bus_if bus_if [mem_subsys_pkg::NUM_BANKS] ();

    logic line_ready;

    line_bus_master u_master (
        .itf        (itf),
        .rst        (rst),
        .req        (req),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .ack        (ack),
        .line_ready (line_ready),
        .banks      (bus_if)
    );

    for (genvar g = 0; g < mem_subsys_pkg::NUM_BANKS; g++) begin : g_bank
        bram_bank u_bank (
            .itf (itf),
            .rst (rst),
            .bus (bus_if[g])
        );
    end

    line_assembler u_assembler (
        .itf        (itf),
        .rst        (rst),
        .banks      (bus_if),
        .rdata      (rdata),
        .line_ready (line_ready)
    );

endmodule

`default_nettype wire

//--- hw/line_assembler.sv
// Gathers the read beats of the answering bank into a full line for the top level
`timescale 1ns/10ps
`default_nettype none

module line_assembler (
    input  wire logic               itf,
    input  wire logic               rst,
    bram_bus_if.mon                 banks [mem_subsys_pkg::NUM_BANKS],
    output mem_subsys_pkg::line_t   rdata,
    output logic                    line_ready
);

    logic [mem_subsys_pkg::NUM_BANKS-1:0] hit;
    mem_subsys_pkg::bus_word_t beat_v [mem_subsys_pkg::NUM_BANKS];
    mem_subsys_pkg::bus_word_t beat_sel;
    logic                      hit_any;
    logic                      addr_seen;
    logic                      beat_take;
    mem_subsys_pkg::beat_idx_t cnt;
    mem_subsys_pkg::line_t     line_q;

    for (genvar g = 0; g < mem_subsys_pkg::NUM_BANKS; g++) begin : g_snoop
        assign hit[g]    = banks[g].read_en && banks[g].resp;
        assign beat_v[g] = banks[g].bus_m_to_c;
    end

    // at most one bank answers at a time
    always_comb begin
        beat_sel = '0;
        for (int i = 0; i < mem_subsys_pkg::NUM_BANKS; i++) begin
            if (hit[i]) begin
                beat_sel = beat_sel | beat_v[i];
            end
        end
    end

    assign hit_any = |hit;

    // the address beat answers first and carries no line data
    assign beat_take = hit_any && addr_seen;

    always_ff @(posedge itf) begin
        if (rst) begin
            cnt        <= '0;
            addr_seen  <= 1'b0;
            line_ready <= 1'b0;
        end else begin
            line_ready <= beat_take &&
                          (cnt == mem_subsys_pkg::beat_idx_t'(mem_subsys_pkg::BEATS - 1));
            if (hit_any && !addr_seen) begin
                addr_seen <= 1'b1;
            end
            // wraps back to zero after the eighth beat
            if (beat_take) begin
                cnt <= cnt + 1'b1;
                if (cnt == mem_subsys_pkg::beat_idx_t'(mem_subsys_pkg::BEATS - 1)) begin
                    addr_seen <= 1'b0;
                end
            end
        end
    end

    // shift in from the top so beat 0 ends up in the low bits
    always_ff @(posedge itf) begin
        if (beat_take) begin
            line_q <= {beat_sel, line_q[mem_subsys_pkg::LINE_W-1:mem_subsys_pkg::BUS_W]};
        end
    end

    assign rdata = line_q;

endmodule

`default_nettype wire

//--- hw/bram_bank.sv
// One memory bank: beat protocol FSM in front of a 64-bit word array, one per bus interface
`timescale 1ns/10ps
`default_nettype none

module bram_bank (
    input  wire logic itf,
    input  wire logic rst,
    bram_bus_if.mem   bus
);

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_wdata,
        st_fetch,
        st_read,
        st_recover
    } bstate_t;

    bstate_t state, next_state;

    mem_subsys_pkg::mem_word_t mem [mem_subsys_pkg::BANK_WORDS];

    mem_subsys_pkg::line_idx_t line_q;
    mem_subsys_pkg::beat_idx_t beat_q;

    // write packing
    mem_subsys_pkg::bus_word_t lo_q;
    mem_subsys_pkg::mem_word_t wr_word;
    logic [$clog2(mem_subsys_pkg::BANK_WORDS)-1:0] wr_idx;
    logic wr_pend;

    logic [$clog2(mem_subsys_pkg::BANK_WORDS)-1:0] rd_idx;
    mem_subsys_pkg::mem_word_t rd_word;
    logic addr_take;
    logic data_take;

    assign addr_take = (state == st_addr) && bus.address_on;
    assign data_take = (state == st_wdata) && bus.data_on;

    // resp is combinational for address and write beats
    assign bus.resp = addr_take || data_take || (state == st_read);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (bus.read_en || bus.write_en) begin
                    next_state = st_addr;
                end
            end
            st_addr: begin
                if (bus.address_on) begin
                    next_state = bus.write_en ? st_wdata : st_fetch;
                end
            end
            st_wdata: begin
                if (bus.data_on && beat_q == mem_subsys_pkg::beat_idx_t'(mem_subsys_pkg::BEATS - 1)) begin
                    next_state = st_recover;
                end
            end
            st_fetch: begin
                next_state = st_read;
            end
            st_read: begin
                // pointer runs one ahead of the beat on the bus and wraps on the last one
                if (beat_q == '0) begin
                    next_state = st_recover;
                end
            end
            st_recover: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge itf) begin
        if (rst) begin
            state   <= st_idle;
            beat_q  <= '0;
            wr_pend <= 1'b0;
        end else begin
            state   <= next_state;
            wr_pend <= data_take && beat_q[0];
            if (addr_take) begin
                beat_q <= '0;
            end else if (data_take || state == st_fetch || state == st_read) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // odd beat completes a word, it lands in the array next cycle
    always_ff @(posedge itf) begin
        if (addr_take) begin
            line_q <= bus.bus_c_to_m[$bits(mem_subsys_pkg::line_idx_t)-1:0];
        end
        if (data_take) begin
            if (!beat_q[0]) begin
                lo_q <= bus.bus_c_to_m;
            end else begin
                wr_word <= {bus.bus_c_to_m, lo_q};
                wr_idx  <= {line_q, beat_q[2:1]};
            end
        end
    end

    assign rd_idx  = {line_q, beat_q[2:1]};
    assign rd_word = mem[rd_idx];

    always_ff @(posedge itf) begin
        if (wr_pend) begin
            mem[wr_idx] <= wr_word;
        end
        // registered read beat, low half first
        if (state == st_fetch || state == st_read) begin
            bus.bus_m_to_c <= beat_q[0] ? rd_word[63:32] : rd_word[31:0];
        end
    end

endmodule

`default_nettype wire

//--- hw/line_bus_master.sv
// Line bus master: converts host line requests into beat transactions on one selected bank
`timescale 1ns/10ps
`default_nettype none

module line_bus_master (
    input  wire logic                   itf,
    input  wire logic                   rst,
    input  wire logic                   req,
    input  wire logic                   we,
    input  wire mem_subsys_pkg::addr_t  addr,
    input  wire mem_subsys_pkg::line_t  wdata,
    output logic                        ack,
    input  wire logic                   line_ready,
    bram_bus_if.ctrl                    banks [mem_subsys_pkg::NUM_BANKS]
);

    typedef enum logic [2:0] {
        m_idle,
        m_addr,
        m_wbeat,
        m_wait_line,
        m_hold_ack
    } mstate_t;

    mstate_t state;

    // latched request
    logic                          we_q;
    mem_subsys_pkg::bank_idx_t     bank_q;
    mem_subsys_pkg::line_idx_t     line_q;
    mem_subsys_pkg::line_t         wdata_q;
    mem_subsys_pkg::beat_idx_t     beat_q;

    logic                          rd_on;
    logic                          wr_on;
    mem_subsys_pkg::bus_word_t     bus_out;
    logic [mem_subsys_pkg::NUM_BANKS-1:0] resp_v;
    logic                          resp_sel;

    // enables stay up from the address beat to the end of the data phase
    assign rd_on = !we_q && (state == m_addr || state == m_wait_line);
    assign wr_on = we_q && (state == m_addr || state == m_wbeat);

    // address beat carries only the line index, the bank is implied by the enable
    assign bus_out = (state == m_addr) ? mem_subsys_pkg::bus_word_t'(line_q)
                                       : wdata_q[beat_q*mem_subsys_pkg::BUS_W +:
                                                 mem_subsys_pkg::BUS_W];

    for (genvar g = 0; g < mem_subsys_pkg::NUM_BANKS; g++) begin : g_drive
        logic sel;

        assign sel                 = (bank_q == mem_subsys_pkg::bank_idx_t'(g));
        assign banks[g].read_en    = sel && rd_on;
        assign banks[g].write_en   = sel && wr_on;
        assign banks[g].address_on = sel && (state == m_addr);
        assign banks[g].data_on    = sel && (state == m_wbeat);
        assign banks[g].bus_c_to_m = bus_out;
        assign resp_v[g]           = banks[g].resp;
    end

    assign resp_sel = resp_v[bank_q];

    always_ff @(posedge itf) begin
        if (rst) begin
            state  <= m_idle;
            ack    <= 1'b0;
            beat_q <= '0;
        end else begin
            case (state)
                m_idle: begin
                    if (req) begin
                        state <= m_addr;
                    end
                end
                m_addr: begin
                    if (resp_sel) begin
                        beat_q <= '0;
                        state  <= we_q ? m_wbeat : m_wait_line;
                    end
                end
                m_wbeat: begin
                    // one beat per resp, done once the eighth is accepted
                    if (resp_sel) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == mem_subsys_pkg::beat_idx_t'(mem_subsys_pkg::BEATS - 1)) begin
                            state <= m_hold_ack;
                            ack   <= 1'b1;
                        end
                    end
                end
                m_wait_line: begin
                    if (line_ready) begin
                        state <= m_hold_ack;
                        ack   <= 1'b1;
                    end
                end
                m_hold_ack: begin
                    // four-phase release
                    if (!req) begin
                        state <= m_idle;
                        ack   <= 1'b0;
                    end
                end
                default: begin
                    state <= m_idle;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // request capture, address bits 6..5 pick the bank and 10..7 the line
    always_ff @(posedge itf) begin
        if (state == m_idle && req) begin
            we_q    <= we;
            bank_q  <= addr[6:5];
            line_q  <= addr[10:7];
            wdata_q <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/bram_bus_if.sv
// Narrow multiplexed address/data bus that links the line master to a single bank
`timescale 1ns/10ps
`default_nettype none

interface bram_bus_if;

    // held by the master for the whole transaction
    logic read_en;
    logic write_en;

    // beat qualifiers from the master
    logic address_on;
    logic data_on;
    mem_subsys_pkg::bus_word_t bus_c_to_m;

    // bank side
    logic resp;
    mem_subsys_pkg::bus_word_t bus_m_to_c;

    modport ctrl (
        output read_en, write_en, address_on, data_on, bus_c_to_m,
        input  resp, bus_m_to_c
    );

    modport mem (
        input  read_en, write_en, address_on, data_on, bus_c_to_m,
        output resp, bus_m_to_c
    );

    // read-side snoop used by the line assembler
    modport mon (
        input read_en, resp, bus_m_to_c
    );

endinterface

`default_nettype wire

//--- hw/mem_subsys_pkg.sv
// Shared widths, bank geometry and vector types for the line memory subsystem
`default_nettype none

package mem_subsys_pkg;

    // narrow multiplexed bus and storage widths
    localparam int BUS_W  = 32;
    localparam int WORD_W = 64;
    localparam int LINE_W = 256;

    // one line moves as eight narrow beats
    localparam int BEATS = LINE_W / BUS_W;

    // bank geometry
    localparam int NUM_BANKS      = 4;
    localparam int BANK_BITS      = 2;
    localparam int LINES_PER_BANK = 16;
    localparam int BANK_WORDS     = LINES_PER_BANK * LINE_W / WORD_W;

    // byte address, offset bits 4..0 and bits above 10 are ignored
    typedef logic [31:0]         addr_t;
    typedef logic [BUS_W-1:0]    bus_word_t;
    typedef logic [WORD_W-1:0]   mem_word_t;

    // beat k sits at line bits 32k upward
    typedef logic [LINE_W-1:0]   line_t;

    // bank number from address bits 6..5
    typedef logic [BANK_BITS-1:0] bank_idx_t;

    // line inside a bank from address bits 10..7
    typedef logic [$clog2(LINES_PER_BANK)-1:0] line_idx_t;

    typedef logic [$clog2(BEATS)-1:0] beat_idx_t;

endpackage

`default_nettype wire
